// ==== verilog/wb_inter_pkg.sv ====
// Wishbone interconnect shared definitions
`default_nettype none

package wb_inter_pkg;

  // Bus widths
  localparam int WB_DW = 32;
  localparam int WB_AW = 32;
  localparam int WB_SW = 4;

  // Target id width and master count
  localparam int TID_W   = 2;
  localparam int NUM_MST = 3;

  // Target ids, one per target port
  localparam logic [TID_W-1:0] TARGET_SPI    = 2'd0;
  localparam logic [TID_W-1:0] TARGET_UART   = 2'd1;
  localparam logic [TID_W-1:0] TARGET_PINMUX = 2'd2;

  // -------------------------------------------------------------------------
  // Memory map
  // 0x0xxx_xxxx      QSPI memory
  // 0x1000_xxxx      QSPI registers
  // 0x1001_xxxx      UART block
  // 0x1002_xxxx      pin mux
  // -------------------------------------------------------------------------
  localparam logic [3:0]  REGION_SPI_MEM = 4'h0;
  localparam logic [15:0] PAGE_SPI_REG   = 16'h1000;
  localparam logic [15:0] PAGE_UART      = 16'h1001;
  localparam logic [15:0] PAGE_PINMUX    = 16'h1002;

  // Default narrow address widths of target 1 and target 2
  localparam int S1_AW = 9;
  localparam int S2_AW = 10;

  // Address word, seen as region nibble or as 16-bit page
  typedef union packed {
    struct packed {
      logic [3:0]  region;
      logic [27:0] rest;
    } rgn;
    struct packed {
      logic [15:0] page;
      logic [15:0] offset;
    } pg;
  } wb_addr_u;

endpackage

`default_nettype wire

// ==== verilog/wb_addr_decode.sv ====
// Wishbone address decoder
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
  // Master address
  input  wire logic [wb_inter_pkg::WB_AW-1:0] wbd_adr_i,
  // Target id of that address
  output logic      [wb_inter_pkg::TID_W-1:0] wbd_tid_o
);

  import wb_inter_pkg::*;

  // Address viewed both ways
  wb_addr_u adr_u;

  assign adr_u = wbd_adr_i;

  // -------------------------------------------------------------------------
  // Map decode
  // -------------------------------------------------------------------------
  always_comb begin
    // Region test has priority over the page tests
    if (adr_u.rgn.region == REGION_SPI_MEM) begin
      wbd_tid_o = TARGET_SPI;
    end else begin
      case (adr_u.pg.page)
        // QSPI register page shares the memory port
        PAGE_SPI_REG: begin
          wbd_tid_o = TARGET_SPI;
        end
        // UART block
        PAGE_UART: begin
          wbd_tid_o = TARGET_UART;
        end
        // Pin mux
        PAGE_PINMUX: begin
          wbd_tid_o = TARGET_PINMUX;
        end
        // Unmapped space falls back to the QSPI port
        default: begin
          wbd_tid_o = TARGET_SPI;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wb_target_port.sv ====
// Wishbone target port with round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module wb_target_port #(
  // Id this port answers to
  parameter logic [wb_inter_pkg::TID_W-1:0] TARGET_ID = wb_inter_pkg::TARGET_SPI
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,

  // Master requests, one entry per master
  input  wire logic [wb_inter_pkg::NUM_MST-1:0][wb_inter_pkg::WB_DW-1:0] m_dat_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0][wb_inter_pkg::WB_AW-1:0] m_adr_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0][wb_inter_pkg::WB_SW-1:0] m_sel_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0]                          m_we_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0]                          m_cyc_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0]                          m_stb_i,
  input  wire logic [wb_inter_pkg::NUM_MST-1:0][wb_inter_pkg::TID_W-1:0] m_tid_i,

  // Responses back to each master
  output logic      [wb_inter_pkg::NUM_MST-1:0][wb_inter_pkg::WB_DW-1:0] m_dat_o,
  output logic      [wb_inter_pkg::NUM_MST-1:0]                          m_ack_o,

  // Target response
  input  wire logic [wb_inter_pkg::WB_DW-1:0]                            s_dat_i,
  input  wire logic                                                      s_ack_i,

  // Target request
  output logic      [wb_inter_pkg::WB_DW-1:0]                            s_dat_o,
  output logic      [wb_inter_pkg::WB_AW-1:0]                            s_adr_o,
  output logic      [wb_inter_pkg::WB_SW-1:0]                            s_sel_o,
  output logic                                                           s_we_o,
  output logic                                                           s_cyc_o,
  output logic                                                           s_stb_o
);

  import wb_inter_pkg::*;

  // Width of a master index
  localparam int IDX_W = $clog2(NUM_MST);

  // Masters addressing this port
  logic [NUM_MST-1:0] req;
  // Port owned by a master
  logic               busy_q;
  // Current grant, doubles as last-granted pointer when idle
  logic [IDX_W-1:0]   gnt_q;
  // Arbiter result for the next idle edge
  logic               nxt_vld;
  logic [IDX_W-1:0]   nxt_idx;
  // Granted master still on its cycle to this port
  logic               gnt_hit;

  // -------------------------------------------------------------------------
  // Request detect
  // -------------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_MST; k++) begin
      req[k] = m_cyc_i[k] & m_stb_i[k] & (m_tid_i[k] == TARGET_ID);
    end
  end

  // -------------------------------------------------------------------------
  // Round-robin pick
  // -------------------------------------------------------------------------
  // Search starts one past the last grant and wraps
  always_comb begin : rr_pick
    int unsigned cand;
    nxt_vld = 1'b0;
    nxt_idx = gnt_q;
    for (int i = 1; i <= NUM_MST; i++) begin
      cand = (int'(gnt_q) + i) % NUM_MST;
      if (!nxt_vld && req[cand]) begin
        nxt_vld = 1'b1;
        nxt_idx = IDX_W'(cand);
      end
    end
  end

  // Owner keeps the port while its cycle stays aimed here
  assign gnt_hit = m_cyc_i[gnt_q] & (m_tid_i[gnt_q] == TARGET_ID);

  // -------------------------------------------------------------------------
  // Grant state
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      // Pointer at m2 so m0 wins first
      gnt_q  <= IDX_W'(NUM_MST - 1);
    end else if (!busy_q) begin
      // Idle, grant on this edge
      if (nxt_vld) begin
        busy_q <= 1'b1;
        gnt_q  <= nxt_idx;
      end
    end else if (!gnt_hit) begin
      // Owner dropped cyc, free the port
      busy_q <= 1'b0;
    end
  end

  // -------------------------------------------------------------------------
  // Request forwarding
  // -------------------------------------------------------------------------
  // Payload follows the grant index directly
  assign s_dat_o = m_dat_i[gnt_q];
  assign s_adr_o = m_adr_i[gnt_q];
  assign s_sel_o = m_sel_i[gnt_q];
  assign s_we_o  = m_we_i[gnt_q];

  // Strobes only while owned
  assign s_cyc_o = busy_q & gnt_hit;
  assign s_stb_o = busy_q & gnt_hit & m_stb_i[gnt_q];

  // -------------------------------------------------------------------------
  // Response steering
  // -------------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_MST; k++) begin
      // Read data goes to everyone, ack only to the owner
      m_dat_o[k] = s_dat_i;
      m_ack_o[k] = busy_q & gnt_hit & s_ack_i & (gnt_q == IDX_W'(k));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wb_resp_mux.sv ====
// Wishbone master response mux
`timescale 1ns/1ps
`default_nettype none

module wb_resp_mux (
  // Target id of this master's current address
  input  wire logic [wb_inter_pkg::TID_W-1:0] tid_i,

  // Read data from each target port
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s0_dat_i,
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s1_dat_i,
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s2_dat_i,

  // Ack from each target port
  input  wire logic                           s0_ack_i,
  input  wire logic                           s1_ack_i,
  input  wire logic                           s2_ack_i,

  // Response to the master
  output logic      [wb_inter_pkg::WB_DW-1:0] dat_o,
  output logic                                ack_o
);

  import wb_inter_pkg::*;

  // -------------------------------------------------------------------------
  // Select by target id
  // -------------------------------------------------------------------------
  always_comb begin
    case (tid_i)
      // UART port
      TARGET_UART: begin
        dat_o = s1_dat_i;
        ack_o = s1_ack_i;
      end
      // Pin mux port
      TARGET_PINMUX: begin
        dat_o = s2_dat_i;
        ack_o = s2_ack_i;
      end
      // QSPI port, also the decode fallback
      default: begin
        dat_o = s0_dat_i;
        ack_o = s0_ack_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/wb_interconnect.sv ====
// Wishbone shared-bus interconnect
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect #(
  // Address width of the UART port
  parameter int S1_AW = wb_inter_pkg::S1_AW,
  // Address width of the pin mux port
  parameter int S2_AW = wb_inter_pkg::S2_AW
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,

  // Master 0, external host
  input  wire logic [wb_inter_pkg::WB_DW-1:0] m0_wbd_dat_i,
  input  wire logic [wb_inter_pkg::WB_AW-1:0] m0_wbd_adr_i,
  input  wire logic [wb_inter_pkg::WB_SW-1:0] m0_wbd_sel_i,
  input  wire logic                           m0_wbd_we_i,
  input  wire logic                           m0_wbd_cyc_i,
  input  wire logic                           m0_wbd_stb_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] m0_wbd_dat_o,
  output logic                                m0_wbd_ack_o,

  // Master 1, RISC instruction port
  input  wire logic [wb_inter_pkg::WB_DW-1:0] m1_wbd_dat_i,
  input  wire logic [wb_inter_pkg::WB_AW-1:0] m1_wbd_adr_i,
  input  wire logic [wb_inter_pkg::WB_SW-1:0] m1_wbd_sel_i,
  input  wire logic                           m1_wbd_we_i,
  input  wire logic                           m1_wbd_cyc_i,
  input  wire logic                           m1_wbd_stb_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] m1_wbd_dat_o,
  output logic                                m1_wbd_ack_o,

  // Master 2, RISC data port
  input  wire logic [wb_inter_pkg::WB_DW-1:0] m2_wbd_dat_i,
  input  wire logic [wb_inter_pkg::WB_AW-1:0] m2_wbd_adr_i,
  input  wire logic [wb_inter_pkg::WB_SW-1:0] m2_wbd_sel_i,
  input  wire logic                           m2_wbd_we_i,
  input  wire logic                           m2_wbd_cyc_i,
  input  wire logic                           m2_wbd_stb_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] m2_wbd_dat_o,
  output logic                                m2_wbd_ack_o,

  // Target 0, QSPI memory and registers
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s0_wbd_dat_i,
  input  wire logic                           s0_wbd_ack_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] s0_wbd_dat_o,
  output logic      [wb_inter_pkg::WB_AW-1:0] s0_wbd_adr_o,
  output logic      [wb_inter_pkg::WB_SW-1:0] s0_wbd_sel_o,
  output logic                                s0_wbd_we_o,
  output logic                                s0_wbd_cyc_o,
  output logic                                s0_wbd_stb_o,

  // Target 1, UART block
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s1_wbd_dat_i,
  input  wire logic                           s1_wbd_ack_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] s1_wbd_dat_o,
  output logic      [S1_AW-1:0]               s1_wbd_adr_o,
  output logic      [wb_inter_pkg::WB_SW-1:0] s1_wbd_sel_o,
  output logic                                s1_wbd_we_o,
  output logic                                s1_wbd_cyc_o,
  output logic                                s1_wbd_stb_o,

  // Target 2, pin mux
  input  wire logic [wb_inter_pkg::WB_DW-1:0] s2_wbd_dat_i,
  input  wire logic                           s2_wbd_ack_i,
  output logic      [wb_inter_pkg::WB_DW-1:0] s2_wbd_dat_o,
  output logic      [S2_AW-1:0]               s2_wbd_adr_o,
  output logic      [wb_inter_pkg::WB_SW-1:0] s2_wbd_sel_o,
  output logic                                s2_wbd_we_o,
  output logic                                s2_wbd_cyc_o,
  output logic                                s2_wbd_stb_o
);

  import wb_inter_pkg::*;

  // Target id per master
  logic [TID_W-1:0] m0_tid;
  logic [TID_W-1:0] m1_tid;
  logic [TID_W-1:0] m2_tid;

  // Master requests packed for the target ports, m0 at index 0
  logic [NUM_MST-1:0][WB_DW-1:0] m_dat;
  logic [NUM_MST-1:0][WB_AW-1:0] m_adr;
  logic [NUM_MST-1:0][WB_SW-1:0] m_sel;
  logic [NUM_MST-1:0]            m_we;
  logic [NUM_MST-1:0]            m_cyc;
  logic [NUM_MST-1:0]            m_stb;
  logic [NUM_MST-1:0][TID_W-1:0] m_tid;

  // Per-master returns of each target port
  logic [NUM_MST-1:0][WB_DW-1:0] tp0_dat;
  logic [NUM_MST-1:0][WB_DW-1:0] tp1_dat;
  logic [NUM_MST-1:0][WB_DW-1:0] tp2_dat;
  logic [NUM_MST-1:0]            tp0_ack;
  logic [NUM_MST-1:0]            tp1_ack;
  logic [NUM_MST-1:0]            tp2_ack;

  // Full-width addresses before the cut
  logic [WB_AW-1:0] s1_adr_full;
  logic [WB_AW-1:0] s2_adr_full;

  // -------------------------------------------------------------------------
  // Address decode
  // -------------------------------------------------------------------------
  wb_addr_decode u_dec0 (.wbd_adr_i(m0_wbd_adr_i), .wbd_tid_o(m0_tid));
  wb_addr_decode u_dec1 (.wbd_adr_i(m1_wbd_adr_i), .wbd_tid_o(m1_tid));
  wb_addr_decode u_dec2 (.wbd_adr_i(m2_wbd_adr_i), .wbd_tid_o(m2_tid));

  // Master bundles
  assign m_dat = {m2_wbd_dat_i, m1_wbd_dat_i, m0_wbd_dat_i};
  assign m_adr = {m2_wbd_adr_i, m1_wbd_adr_i, m0_wbd_adr_i};
  assign m_sel = {m2_wbd_sel_i, m1_wbd_sel_i, m0_wbd_sel_i};
  assign m_we  = {m2_wbd_we_i,  m1_wbd_we_i,  m0_wbd_we_i};
  assign m_cyc = {m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i};
  assign m_stb = {m2_wbd_stb_i, m1_wbd_stb_i, m0_wbd_stb_i};
  assign m_tid = {m2_tid, m1_tid, m0_tid};

  // -------------------------------------------------------------------------
  // Target ports
  // -------------------------------------------------------------------------
  // QSPI
  wb_target_port #(.TARGET_ID(TARGET_SPI)) u_s0 (
    .clk_i   (clk_i),        .rst_n_i (rst_n_i),
    .m_dat_i (m_dat),        .m_adr_i (m_adr),        .m_sel_i (m_sel),
    .m_we_i  (m_we),         .m_cyc_i (m_cyc),        .m_stb_i (m_stb),
    .m_tid_i (m_tid),        .m_dat_o (tp0_dat),      .m_ack_o (tp0_ack),
    .s_dat_i (s0_wbd_dat_i), .s_ack_i (s0_wbd_ack_i),
    .s_dat_o (s0_wbd_dat_o), .s_adr_o (s0_wbd_adr_o), .s_sel_o (s0_wbd_sel_o),
    .s_we_o  (s0_wbd_we_o),  .s_cyc_o (s0_wbd_cyc_o), .s_stb_o (s0_wbd_stb_o)
  );

  // UART
  wb_target_port #(.TARGET_ID(TARGET_UART)) u_s1 (
    .clk_i   (clk_i),        .rst_n_i (rst_n_i),
    .m_dat_i (m_dat),        .m_adr_i (m_adr),        .m_sel_i (m_sel),
    .m_we_i  (m_we),         .m_cyc_i (m_cyc),        .m_stb_i (m_stb),
    .m_tid_i (m_tid),        .m_dat_o (tp1_dat),      .m_ack_o (tp1_ack),
    .s_dat_i (s1_wbd_dat_i), .s_ack_i (s1_wbd_ack_i),
    .s_dat_o (s1_wbd_dat_o), .s_adr_o (s1_adr_full),  .s_sel_o (s1_wbd_sel_o),
    .s_we_o  (s1_wbd_we_o),  .s_cyc_o (s1_wbd_cyc_o), .s_stb_o (s1_wbd_stb_o)
  );

  // Pin mux
  wb_target_port #(.TARGET_ID(TARGET_PINMUX)) u_s2 (
    .clk_i   (clk_i),        .rst_n_i (rst_n_i),
    .m_dat_i (m_dat),        .m_adr_i (m_adr),        .m_sel_i (m_sel),
    .m_we_i  (m_we),         .m_cyc_i (m_cyc),        .m_stb_i (m_stb),
    .m_tid_i (m_tid),        .m_dat_o (tp2_dat),      .m_ack_o (tp2_ack),
    .s_dat_i (s2_wbd_dat_i), .s_ack_i (s2_wbd_ack_i),
    .s_dat_o (s2_wbd_dat_o), .s_adr_o (s2_adr_full),  .s_sel_o (s2_wbd_sel_o),
    .s_we_o  (s2_wbd_we_o),  .s_cyc_o (s2_wbd_cyc_o), .s_stb_o (s2_wbd_stb_o)
  );

  // Narrow targets see only the low address bits
  assign s1_wbd_adr_o = s1_adr_full[S1_AW-1:0];
  assign s2_wbd_adr_o = s2_adr_full[S2_AW-1:0];

  // -------------------------------------------------------------------------
  // Master responses
  // -------------------------------------------------------------------------
  wb_resp_mux u_rsp0 (
    .tid_i    (m0_tid),
    .s0_dat_i (tp0_dat[0]), .s1_dat_i (tp1_dat[0]), .s2_dat_i (tp2_dat[0]),
    .s0_ack_i (tp0_ack[0]), .s1_ack_i (tp1_ack[0]), .s2_ack_i (tp2_ack[0]),
    .dat_o    (m0_wbd_dat_o),
    .ack_o    (m0_wbd_ack_o)
  );

  wb_resp_mux u_rsp1 (
    .tid_i    (m1_tid),
    .s0_dat_i (tp0_dat[1]), .s1_dat_i (tp1_dat[1]), .s2_dat_i (tp2_dat[1]),
    .s0_ack_i (tp0_ack[1]), .s1_ack_i (tp1_ack[1]), .s2_ack_i (tp2_ack[1]),
    .dat_o    (m1_wbd_dat_o),
    .ack_o    (m1_wbd_ack_o)
  );

  wb_resp_mux u_rsp2 (
    .tid_i    (m2_tid),
    .s0_dat_i (tp0_dat[2]), .s1_dat_i (tp1_dat[2]), .s2_dat_i (tp2_dat[2]),
    .s0_ack_i (tp0_ack[2]), .s1_ack_i (tp1_ack[2]), .s2_ack_i (tp2_ack[2]),
    .dat_o    (m2_wbd_dat_o),
    .ack_o    (m2_wbd_ack_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_wb_slave_model.sv ====
// Wishbone target model
`timescale 1ns/1ps
`default_nettype none

module tb_wb_slave_model #(
  // Address width seen by this target
  parameter int         AW  = 32,
  // Target id, folded into the fill pattern
  parameter logic [1:0] TID = 2'd0
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire logic [31:0]   dat_i,
  input  wire logic [AW-1:0] adr_i,
  input  wire logic [3:0]    sel_i,
  input  wire logic          we_i,
  input  wire logic          cyc_i,
  input  wire logic          stb_i,
  output logic      [31:0]   dat_o,
  output logic               ack_o
);

  // 64-word store indexed by address bits 7:2
  logic [31:0] mem [64];
  // Waiting on a request already seen
  logic        busy_q;
  int          wait_q;

  // Fill depends on target id and the whole word index
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (32'(TID) << 24) ^ (32'(i) * 32'h0001_0101);
    end
  end

  // -------------------------------------------------------------------------
  // Response with a random wait of 0 to 3 cycles
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin : resp_proc
    int left;
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= 0;
      dat_o  <= 32'h0;
    end else if (ack_o) begin
      // Single ack pulse per transfer
      ack_o  <= 1'b0;
      busy_q <= 1'b0;
    end else if (cyc_i && stb_i) begin
      // New request draws its wait
      left = busy_q ? wait_q : int'($urandom % 4);
      if (left == 0) begin
        ack_o <= 1'b1;
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem[adr_i[7:2]][8*b +: 8] <= dat_i[8*b +: 8];
            end
          end
        end else begin
          dat_o <= mem[adr_i[7:2]];
        end
      end else begin
        busy_q <= 1'b1;
        wait_q <= left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_wb_interconnect.sv ====
// Wishbone interconnect testbench
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

  localparam int          S1_AW    = wb_inter_pkg::S1_AW;
  localparam int          S2_AW    = wb_inter_pkg::S2_AW;
  localparam int          NUM_XFER = 200;
  // Six cycles per transfer for every master plus margin
  localparam int          TIMEOUT  = NUM_XFER * 3 * 6 + 400;
  localparam logic [31:0] SEED     = 32'hfd38_1e34;

  logic clk = 1'b0;
  logic rst_n;

  // Master side of the DUT
  logic [31:0] m_wdat [3];
  logic [31:0] m_adr  [3];
  logic [3:0]  m_sel  [3];
  logic        m_we   [3];
  logic        m_cyc  [3];
  logic        m_stb  [3];
  logic [31:0] m_rdat [3];
  logic        m_ack  [3];

  // Target side with addresses widened to 32 bits
  logic [31:0]      t_rdat [3];
  logic [31:0]      t_wdat [3];
  logic [31:0]      t_adr  [3];
  logic [3:0]       t_sel  [3];
  logic             t_ack  [3];
  logic             t_we   [3];
  logic             t_cyc  [3];
  logic             t_stb  [3];
  logic [S1_AW-1:0] s1_adr;
  logic [S2_AW-1:0] s2_adr;

  // Reference model and checker state
  logic [1:0]  req_tid  [3];
  logic        req_act  [3];
  logic [31:0] ref_mem  [3][64];
  logic [2:0]  waiting  [3];
  logic        prev_cyc [3];
  int          last_gnt [3];
  int          owner    [3];
  int          grants   [3];
  int          issued   [3];
  int          cycles = 0;

  always #50 clk = ~clk;

  // -------------------------------------------------------------------------
  // DUT and target models
  // -------------------------------------------------------------------------
  wb_interconnect #(.S1_AW(S1_AW), .S2_AW(S2_AW)) u_dut (
    .clk_i        (clk),       .rst_n_i      (rst_n),
    .m0_wbd_dat_i (m_wdat[0]), .m0_wbd_adr_i (m_adr[0]), .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i  (m_we[0]),   .m0_wbd_cyc_i (m_cyc[0]), .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]), .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_dat_i (m_wdat[1]), .m1_wbd_adr_i (m_adr[1]), .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i  (m_we[1]),   .m1_wbd_cyc_i (m_cyc[1]), .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]), .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_dat_i (m_wdat[2]), .m2_wbd_adr_i (m_adr[2]), .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i  (m_we[2]),   .m2_wbd_cyc_i (m_cyc[2]), .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]), .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_dat_i (t_rdat[0]), .s0_wbd_ack_i (t_ack[0]),
    .s0_wbd_dat_o (t_wdat[0]), .s0_wbd_adr_o (t_adr[0]), .s0_wbd_sel_o (t_sel[0]),
    .s0_wbd_we_o  (t_we[0]),   .s0_wbd_cyc_o (t_cyc[0]), .s0_wbd_stb_o (t_stb[0]),
    .s1_wbd_dat_i (t_rdat[1]), .s1_wbd_ack_i (t_ack[1]),
    .s1_wbd_dat_o (t_wdat[1]), .s1_wbd_adr_o (s1_adr),   .s1_wbd_sel_o (t_sel[1]),
    .s1_wbd_we_o  (t_we[1]),   .s1_wbd_cyc_o (t_cyc[1]), .s1_wbd_stb_o (t_stb[1]),
    .s2_wbd_dat_i (t_rdat[2]), .s2_wbd_ack_i (t_ack[2]),
    .s2_wbd_dat_o (t_wdat[2]), .s2_wbd_adr_o (s2_adr),   .s2_wbd_sel_o (t_sel[2]),
    .s2_wbd_we_o  (t_we[2]),   .s2_wbd_cyc_o (t_cyc[2]), .s2_wbd_stb_o (t_stb[2])
  );

  assign t_adr[1] = 32'(s1_adr);
  assign t_adr[2] = 32'(s2_adr);

  tb_wb_slave_model #(.AW(32), .TID(2'd0)) u_slv0 (
    .clk_i (clk), .rst_n_i (rst_n), .dat_i (t_wdat[0]), .adr_i (t_adr[0]),
    .sel_i (t_sel[0]), .we_i (t_we[0]), .cyc_i (t_cyc[0]), .stb_i (t_stb[0]),
    .dat_o (t_rdat[0]), .ack_o (t_ack[0])
  );
  tb_wb_slave_model #(.AW(S1_AW), .TID(2'd1)) u_slv1 (
    .clk_i (clk), .rst_n_i (rst_n), .dat_i (t_wdat[1]), .adr_i (s1_adr),
    .sel_i (t_sel[1]), .we_i (t_we[1]), .cyc_i (t_cyc[1]), .stb_i (t_stb[1]),
    .dat_o (t_rdat[1]), .ack_o (t_ack[1])
  );
  tb_wb_slave_model #(.AW(S2_AW), .TID(2'd2)) u_slv2 (
    .clk_i (clk), .rst_n_i (rst_n), .dat_i (t_wdat[2]), .adr_i (s2_adr),
    .sel_i (t_sel[2]), .we_i (t_we[2]), .cyc_i (t_cyc[2]), .stb_i (t_stb[2]),
    .dat_o (t_rdat[2]), .ack_o (t_ack[2])
  );

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // Byte lanes enabled by sel take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Address bits a target actually receives
  function automatic logic [31:0] adr_mask(input int j);
    if (j == 1) begin
      return (32'h1 << S1_AW) - 32'h1;
    end else if (j == 2) begin
      return (32'h1 << S2_AW) - 32'h1;
    end
    return 32'hffff_ffff;
  endfunction

  // One master issuing random single transfers
  task automatic run_master(input int m);
    int unsigned r;
    logic [1:0]  tid;
    logic [31:0] adr;
    logic [5:0]  idx;
    for (int n = 0; n < NUM_XFER; n++) begin
      r = $urandom;
      // Address from the memory map with a random offset
      case ($urandom % 5)
        0: begin
          adr = {4'h0, r[27:0]};
          tid = 2'd0;
        end
        1: begin
          adr = {16'h1000, r[15:0]};
          tid = 2'd0;
        end
        2: begin
          adr = {16'h1001, r[15:0]};
          tid = 2'd1;
        end
        3: begin
          adr = {16'h1002, r[15:0]};
          tid = 2'd2;
        end
        default: begin
          // Unmapped space goes to target 0
          if (r[31]) begin
            adr = {16'h1003 + 16'(r[17:16]), r[15:0]};
          end else begin
            adr = {4'h8 | r[30:27], r[27:0]};
          end
          tid = 2'd0;
        end
      endcase
      @(posedge clk);
      #1;
      m_adr[m]   = adr;
      m_wdat[m]  = $urandom;
      m_sel[m]   = 4'($urandom);
      m_we[m]    = 1'($urandom);
      req_tid[m] = tid;
      req_act[m] = 1'b1;
      m_cyc[m]   = 1'b1;
      m_stb[m]   = 1'b1;
      issued[tid]++;
      // Hold the request until acked
      @(negedge clk);
      while (!m_ack[m]) begin
        @(negedge clk);
      end
      idx = adr[7:2];
      if (m_we[m]) begin
        ref_mem[tid][idx] = merge_bytes(ref_mem[tid][idx], m_wdat[m], m_sel[m]);
      end else begin
        check_eq($sformatf("read data m%0d", m), ref_mem[tid][idx], m_rdat[m]);
      end
      @(posedge clk);
      #1;
      m_cyc[m]   = 1'b0;
      m_stb[m]   = 1'b0;
      req_act[m] = 1'b0;
      repeat ($urandom % 2) @(posedge clk);
    end
  endtask

  // -------------------------------------------------------------------------
  // Target monitor
  // -------------------------------------------------------------------------
  // Grant order, forwarded fields and ack isolation
  always @(negedge clk) begin : monitor
    int o;
    int c;
    if (!rst_n) begin
      for (int j = 0; j < 3; j++) begin
        last_gnt[j] = 2;
        owner[j]    = 0;
        grants[j]   = 0;
        prev_cyc[j] = 1'b0;
        waiting[j]  = 3'b000;
      end
    end else begin
      for (int j = 0; j < 3; j++) begin
        // New access goes to the next waiting master after the last one
        if (t_cyc[j] && !prev_cyc[j]) begin
          o = -1;
          for (int i = 1; i <= 3; i++) begin
            c = (last_gnt[j] + i) % 3;
            if (o < 0 && waiting[j][c]) begin
              o = c;
            end
          end
          if (o < 0) begin
            abort_run($sformatf("target %0d started an access with no master waiting", j));
          end
          owner[j]    = o;
          last_gnt[j] = o;
          grants[j]++;
        end
        if (t_cyc[j]) begin
          o = owner[j];
          check_eq($sformatf("stb t%0d", j), 32'd1, 32'(t_stb[j]));
          check_eq($sformatf("owner active t%0d", j), 32'd1, 32'(req_act[o]));
          check_eq($sformatf("adr t%0d", j), m_adr[o] & adr_mask(j), t_adr[j]);
          check_eq($sformatf("sel t%0d", j), 32'(m_sel[o]), 32'(t_sel[j]));
          check_eq($sformatf("we t%0d", j), 32'(m_we[o]), 32'(t_we[j]));
          if (m_we[o]) begin
            check_eq($sformatf("wdat t%0d", j), m_wdat[o], t_wdat[j]);
          end
        end
        prev_cyc[j] = t_cyc[j];
        for (int m = 0; m < 3; m++) begin
          waiting[j][m] = m_cyc[m] && m_stb[m] && (req_tid[m] == 2'(j));
        end
      end
      // Ack only to the owner of an active access
      for (int m = 0; m < 3; m++) begin
        if (m_ack[m]) begin
          if (!req_act[m]) begin
            abort_run($sformatf("master %0d got an ack with no request", m));
          end
          check_eq($sformatf("ack owner m%0d", m), 32'(m), 32'(owner[req_tid[m]]));
          check_eq($sformatf("ack source m%0d", m), 32'd1,
                   32'(t_cyc[req_tid[m]] & t_ack[req_tid[m]]));
        end
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      abort_run("simulation hung and transfers did not finish in time");
    end
  end

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    for (int m = 0; m < 3; m++) begin
      m_wdat[m]  = 32'h0;
      m_adr[m]   = 32'h0;
      m_sel[m]   = 4'h0;
      m_we[m]    = 1'b0;
      m_cyc[m]   = 1'b0;
      m_stb[m]   = 1'b0;
      req_tid[m] = 2'd0;
      req_act[m] = 1'b0;
      issued[m]  = 0;
    end
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < 64; i++) begin
        ref_mem[t][i] = 32'h5a5a_0000 ^ (32'(t) << 24) ^ (32'(i) * 32'h0001_0101);
      end
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet bus after reset
    @(negedge clk);
    for (int j = 0; j < 3; j++) begin
      check_eq($sformatf("reset cyc t%0d", j), 32'd0, 32'(t_cyc[j]));
      check_eq($sformatf("reset ack m%0d", j), 32'd0, 32'(m_ack[j]));
    end
    fork
      run_master(0);
      run_master(1);
      run_master(2);
    join
    repeat (4) @(negedge clk);
    // Every issued transfer reached its target exactly once
    for (int j = 0; j < 3; j++) begin
      check_eq($sformatf("grant count t%0d", j), 32'(issued[j]), 32'(grants[j]));
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_inter.f ====
verilog/wb_inter_pkg.sv
verilog/wb_addr_decode.sv
verilog/wb_target_port.sv
verilog/wb_resp_mux.sv
verilog/wb_interconnect.sv
verification/tb_wb_slave_model.sv
verification/tb_wb_interconnect.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Wishbone interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --top-module tb_wb_interconnect -f wb_inter.f \
  -Mdir obj_dir -o tb_sim || { echo "build FAILED"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation PASSED"
